// File: Bender.yml
package:
  name: axil_io_client

sources:
  - axil_pkg.sv
  - io_msg_pkg.sv
  - axil_req_capture.sv
  - io_credit_counter.sv
  - io_cmd_packer.sv
  - axil_resp_return.sv
  - axil_io_ctrl.sv
  - axil_io_client.sv
  - target: test
    files:
      - tb_io_target_model.sv
      - tb_axil_io_client.sv

// File: axil_io_client.f
axil_pkg.sv
io_msg_pkg.sv
axil_req_capture.sv
io_credit_counter.sv
io_cmd_packer.sv
axil_resp_return.sv
axil_io_ctrl.sv
axil_io_client.sv
tb_io_target_model.sv
tb_axil_io_client.sv

// File: axil_io_client.sv
module axil_io_client
#(
  parameter int unsigned CMD_CREDITS_P = 2
)
(
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  io_msg_pkg::lce_id_t      lce_id_i,
  input  io_msg_pkg::did_t         did_i,
  // AXI4-Lite client port
  input  axil_pkg::axil_addr_t     awaddr_i,
  input  logic                     awvalid_i,
  output logic                     awready_o,
  input  axil_pkg::axil_data_t     wdata_i,
  input  axil_pkg::axil_strb_t     wstrb_i,
  input  logic                     wvalid_i,
  output logic                     wready_o,
  output axil_pkg::axil_resp_t     bresp_o,
  output logic                     bvalid_o,
  input  logic                     bready_i,
  input  axil_pkg::axil_addr_t     araddr_i,
  input  logic                     arvalid_i,
  output logic                     arready_o,
  output axil_pkg::axil_data_t     rdata_o,
  output axil_pkg::axil_resp_t     rresp_o,
  output logic                     rvalid_o,
  input  logic                     rready_i,
  // Credited command channel
  output logic                     io_cmd_v_o,
  output io_msg_pkg::io_msg_type_e io_cmd_type_o,
  output io_msg_pkg::io_msg_size_e io_cmd_size_o,
  output axil_pkg::axil_addr_t     io_cmd_addr_o,
  output axil_pkg::axil_data_t     io_cmd_data_o,
  output io_msg_pkg::lce_id_t      io_cmd_lce_id_o,
  output io_msg_pkg::did_t         io_cmd_did_o,
  input  logic                     io_cmd_credit_i,
  // Credited response channel
  input  logic                     io_resp_v_i,
  input  io_msg_pkg::io_msg_type_e io_resp_type_i,
  input  axil_pkg::axil_data_t     io_resp_data_i,
  output logic                     io_resp_credit_o
);

  logic                     wr_pend;
  logic                     rd_pend;
  logic                     wr_take;
  logic                     rd_take;
  logic                     credit_avail;
  logic                     cmd_issue;
  logic                     load;
  io_msg_pkg::io_msg_type_e cmd_type;
  axil_pkg::axil_addr_t     wr_addr;
  axil_pkg::axil_addr_t     rd_addr;
  axil_pkg::axil_data_t     wr_data;
  axil_pkg::axil_strb_t     wr_strb;

  axil_req_capture u_req_capture
  (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .awaddr_i  (awaddr_i),
    .awvalid_i (awvalid_i),
    .awready_o (awready_o),
    .wdata_i   (wdata_i),
    .wstrb_i   (wstrb_i),
    .wvalid_i  (wvalid_i),
    .wready_o  (wready_o),
    .araddr_i  (araddr_i),
    .arvalid_i (arvalid_i),
    .arready_o (arready_o),
    .wr_take_i (wr_take),
    .rd_take_i (rd_take),
    .wr_pend_o (wr_pend),
    .rd_pend_o (rd_pend),
    .wr_addr_o (wr_addr),
    .rd_addr_o (rd_addr),
    .wr_data_o (wr_data),
    .wr_strb_o (wr_strb)
  );

  axil_io_ctrl u_ctrl
  (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .wr_pend_i      (wr_pend),
    .rd_pend_i      (rd_pend),
    .credit_avail_i (credit_avail),
    .wr_take_o      (wr_take),
    .rd_take_o      (rd_take),
    .cmd_issue_o    (cmd_issue),
    .load_o         (load),
    .type_o         (cmd_type)
  );

  io_credit_counter #(
    .CMD_CREDITS_P (CMD_CREDITS_P)
  ) u_credit_counter
  (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .cmd_issue_i    (cmd_issue),
    .cmd_credit_i   (io_cmd_credit_i),
    .credit_avail_o (credit_avail)
  );

  io_cmd_packer u_cmd_packer
  (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .load_i          (load),
    .type_i          (cmd_type),
    .wr_addr_i       (wr_addr),
    .rd_addr_i       (rd_addr),
    .wr_data_i       (wr_data),
    .wr_strb_i       (wr_strb),
    .lce_id_i        (lce_id_i),
    .did_i           (did_i),
    .io_cmd_v_o      (io_cmd_v_o),
    .io_cmd_type_o   (io_cmd_type_o),
    .io_cmd_size_o   (io_cmd_size_o),
    .io_cmd_addr_o   (io_cmd_addr_o),
    .io_cmd_data_o   (io_cmd_data_o),
    .io_cmd_lce_id_o (io_cmd_lce_id_o),
    .io_cmd_did_o    (io_cmd_did_o)
  );

  axil_resp_return u_resp_return
  (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .io_resp_v_i      (io_resp_v_i),
    .io_resp_type_i   (io_resp_type_i),
    .io_resp_data_i   (io_resp_data_i),
    .io_resp_credit_o (io_resp_credit_o),
    .bvalid_o         (bvalid_o),
    .bready_i         (bready_i),
    .bresp_o          (bresp_o),
    .rvalid_o         (rvalid_o),
    .rready_i         (rready_i),
    .rresp_o          (rresp_o),
    .rdata_o          (rdata_o)
  );

endmodule

// File: axil_io_ctrl.sv
module axil_io_ctrl
(
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     wr_pend_i,
  input  logic                     rd_pend_i,
  input  logic                     credit_avail_i,
  output logic                     wr_take_o,
  output logic                     rd_take_o,
  output logic                     cmd_issue_o,
  output logic                     load_o,
  output io_msg_pkg::io_msg_type_e type_o
);

  typedef enum logic
  {
    e_ctrl_rd_prio,
    e_ctrl_wr_prio
  } ctrl_state_e;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        pick_wr;
  logic        pick_rd;

  // Pick one direction per cycle, the favoured one wins a tie
  always_comb
  begin
    pick_wr = 1'b0;
    pick_rd = 1'b0;
    if (credit_avail_i)
    begin
      case (state_q)
        e_ctrl_rd_prio:
        begin
          pick_rd = rd_pend_i;
          pick_wr = wr_pend_i & ~rd_pend_i;
        end
        e_ctrl_wr_prio:
        begin
          pick_wr = wr_pend_i;
          pick_rd = rd_pend_i & ~wr_pend_i;
        end
      endcase
    end
  end

  // Favour the other direction after each issue
  always_comb
  begin
    state_d = state_q;
    if (pick_rd)
      state_d = e_ctrl_wr_prio;
    else if (pick_wr)
      state_d = e_ctrl_rd_prio;
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      state_q <= e_ctrl_rd_prio;
    else
      state_q <= state_d;
  end

  assign wr_take_o   = pick_wr;
  assign rd_take_o   = pick_rd;
  assign cmd_issue_o = pick_wr | pick_rd;
  assign load_o      = pick_wr | pick_rd;
  assign type_o      = pick_wr ? io_msg_pkg::e_io_uc_wr : io_msg_pkg::e_io_uc_rd;

endmodule

// File: axil_pkg.sv
package axil_pkg;

  // Bus widths of the AXI4-Lite client port
  localparam int unsigned AXIL_ADDR_W = 32;
  localparam int unsigned AXIL_DATA_W = 32;
  localparam int unsigned AXIL_STRB_W = AXIL_DATA_W / 8;

  // Payload vectors
  typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
  typedef logic [AXIL_DATA_W-1:0] axil_data_t;
  typedef logic [AXIL_STRB_W-1:0] axil_strb_t;

  // B and R response code
  typedef logic [1:0] axil_resp_t;

  // Only OKAY is ever returned by the bridge
  localparam axil_resp_t AXIL_RESP_OKAY = 2'b00;

endpackage

// File: axil_req_capture.sv
module axil_req_capture
(
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  axil_pkg::axil_addr_t awaddr_i,
  input  logic                awvalid_i,
  output logic                awready_o,
  input  axil_pkg::axil_data_t wdata_i,
  input  axil_pkg::axil_strb_t wstrb_i,
  input  logic                wvalid_i,
  output logic                wready_o,
  input  axil_pkg::axil_addr_t araddr_i,
  input  logic                arvalid_i,
  output logic                arready_o,
  input  logic                wr_take_i,
  input  logic                rd_take_i,
  output logic                wr_pend_o,
  output logic                rd_pend_o,
  output axil_pkg::axil_addr_t wr_addr_o,
  output axil_pkg::axil_addr_t rd_addr_o,
  output axil_pkg::axil_data_t wr_data_o,
  output axil_pkg::axil_strb_t wr_strb_o
);

  logic aw_full_q;
  logic w_full_q;
  logic ar_full_q;
  logic rdy_en_q;

  // Each channel is ready only while its holding register is empty
  // Readies stay low until the first clock after reset
  assign awready_o = rdy_en_q & ~aw_full_q;
  assign wready_o  = rdy_en_q & ~w_full_q;
  assign arready_o = rdy_en_q & ~ar_full_q;

  // A write needs both address and data before it can be issued
  assign wr_pend_o = aw_full_q & w_full_q;
  assign rd_pend_o = ar_full_q;

  // Occupancy flags
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      rdy_en_q  <= 1'b0;
      aw_full_q <= 1'b0;
      w_full_q  <= 1'b0;
      ar_full_q <= 1'b0;
    end
    else
    begin
      rdy_en_q <= 1'b1;
      if (wr_take_i)
      begin
        aw_full_q <= 1'b0;
        w_full_q  <= 1'b0;
      end
      else
      begin
        if (awvalid_i && awready_o)
          aw_full_q <= 1'b1;
        if (wvalid_i && wready_o)
          w_full_q <= 1'b1;
      end
      if (rd_take_i)
        ar_full_q <= 1'b0;
      else if (arvalid_i && arready_o)
        ar_full_q <= 1'b1;
    end
  end

  // Beat payloads
  always_ff @(posedge clk_i)
  begin
    if (awvalid_i && awready_o)
      wr_addr_o <= awaddr_i;
    if (wvalid_i && wready_o)
    begin
      wr_data_o <= wdata_i;
      wr_strb_o <= wstrb_i;
    end
    if (arvalid_i && arready_o)
      rd_addr_o <= araddr_i;
  end

endmodule

// File: axil_resp_return.sv
module axil_resp_return
(
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     io_resp_v_i,
  input  io_msg_pkg::io_msg_type_e io_resp_type_i,
  input  axil_pkg::axil_data_t     io_resp_data_i,
  output logic                     io_resp_credit_o,
  output logic                     bvalid_o,
  input  logic                     bready_i,
  output axil_pkg::axil_resp_t     bresp_o,
  output logic                     rvalid_o,
  input  logic                     rready_i,
  output axil_pkg::axil_resp_t     rresp_o,
  output axil_pkg::axil_data_t     rdata_o
);

  localparam int unsigned DEPTH = io_msg_pkg::RESP_CREDITS;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  io_msg_pkg::io_msg_type_e type_mem [DEPTH];
  axil_pkg::axil_data_t     data_mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             head_v;
  logic             head_wr;
  logic             pop;

  assign head_v  = (count_q != '0);
  assign head_wr = (type_mem[rd_ptr_q] == io_msg_pkg::e_io_uc_wr);

  // Head entry is steered to B or R by its message type
  assign bvalid_o = head_v & head_wr;
  assign rvalid_o = head_v & ~head_wr;
  assign rdata_o  = data_mem[rd_ptr_q];
  assign bresp_o  = axil_pkg::AXIL_RESP_OKAY;
  assign rresp_o  = axil_pkg::AXIL_RESP_OKAY;

  assign pop = (bvalid_o & bready_i) | (rvalid_o & rready_i);

  // Target only sends while it holds a credit, so no full check here
  always_ff @(posedge clk_i)
  begin
    if (io_resp_v_i)
    begin
      type_mem[wr_ptr_q] <= io_resp_type_i;
      data_mem[wr_ptr_q] <= io_resp_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr_q         <= '0;
      rd_ptr_q         <= '0;
      count_q          <= '0;
      io_resp_credit_o <= 1'b0;
    end
    else
    begin
      if (io_resp_v_i)
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (io_resp_v_i && !pop)
        count_q <= count_q + 1'b1;
      else if (pop && !io_resp_v_i)
        count_q <= count_q - 1'b1;
      // Hand the slot back once the beat has left
      io_resp_credit_o <= pop;
    end
  end

endmodule

// File: io_cmd_packer.sv
module io_cmd_packer
(
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       load_i,
  input  io_msg_pkg::io_msg_type_e   type_i,
  input  axil_pkg::axil_addr_t       wr_addr_i,
  input  axil_pkg::axil_addr_t       rd_addr_i,
  input  axil_pkg::axil_data_t       wr_data_i,
  input  axil_pkg::axil_strb_t       wr_strb_i,
  input  io_msg_pkg::lce_id_t        lce_id_i,
  input  io_msg_pkg::did_t           did_i,
  output logic                       io_cmd_v_o,
  output io_msg_pkg::io_msg_type_e   io_cmd_type_o,
  output io_msg_pkg::io_msg_size_e   io_cmd_size_o,
  output axil_pkg::axil_addr_t       io_cmd_addr_o,
  output axil_pkg::axil_data_t       io_cmd_data_o,
  output io_msg_pkg::lce_id_t        io_cmd_lce_id_o,
  output io_msg_pkg::did_t           io_cmd_did_o
);

  logic                     is_wr;
  io_msg_pkg::io_msg_size_e size_d;

  assign is_wr = (type_i == io_msg_pkg::e_io_uc_wr);

  // Size from strobe, sparse or unaligned masks go out as a full word
  always_comb
  begin
    size_d = io_msg_pkg::e_io_size_4;
    if (is_wr)
    begin
      if (wr_strb_i == axil_pkg::axil_strb_t'(4'h1))
        size_d = io_msg_pkg::e_io_size_1;
      else if (wr_strb_i == axil_pkg::axil_strb_t'(4'h3))
        size_d = io_msg_pkg::e_io_size_2;
    end
  end

  // One-cycle valid pulse per load
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      io_cmd_v_o <= 1'b0;
    else
      io_cmd_v_o <= load_i;
  end

  // Header and data
  always_ff @(posedge clk_i)
  begin
    if (load_i)
    begin
      io_cmd_type_o   <= type_i;
      io_cmd_size_o   <= size_d;
      io_cmd_addr_o   <= is_wr ? wr_addr_i : rd_addr_i;
      io_cmd_data_o   <= is_wr ? wr_data_i : '0;
      io_cmd_lce_id_o <= lce_id_i;
      io_cmd_did_o    <= did_i;
    end
  end

endmodule

// File: io_credit_counter.sv
module io_credit_counter
#(
  parameter int unsigned CMD_CREDITS_P = 2
)
(
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic cmd_issue_i,
  input  logic cmd_credit_i,
  output logic credit_avail_o
);

  localparam int unsigned CNT_W = $clog2(CMD_CREDITS_P + 1);

  logic [CNT_W-1:0] count_q;

  // Count starts full, an issue and a return together leave it unchanged
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      count_q <= CNT_W'(CMD_CREDITS_P);
    else if (cmd_issue_i && !cmd_credit_i)
    begin
      if (count_q != '0)
        count_q <= count_q - 1'b1;
    end
    else if (cmd_credit_i && !cmd_issue_i)
    begin
      // Saturate at the target's slot count
      if (count_q != CNT_W'(CMD_CREDITS_P))
        count_q <= count_q + 1'b1;
    end
  end

  assign credit_avail_o = (count_q != '0);

endmodule

// File: io_msg_pkg.sv
package io_msg_pkg;

  // Source LCE id carried in every command header
  localparam int unsigned LCE_ID_W = 4;
  typedef logic [LCE_ID_W-1:0] lce_id_t;

  // Domain id carried in every command header
  localparam int unsigned DID_W = 3;
  typedef logic [DID_W-1:0] did_t;

  // Uncached message types, shared by commands and responses
  typedef enum logic [1:0]
  {
    e_io_uc_rd = 2'b00,
    e_io_uc_wr = 2'b01
  } io_msg_type_e;

  // Access size, encoded as log2 of the byte count
  typedef enum logic [1:0]
  {
    e_io_size_1 = 2'b00,
    e_io_size_2 = 2'b01,
    e_io_size_4 = 2'b10
  } io_msg_size_e;

  // Response buffer depth, equal to the credits the target starts with
  localparam int unsigned RESP_CREDITS = 2;

endpackage

// File: tb_axil_io_client.sv
module tb_axil_io_client;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_TXN = 68;

  logic                     clk_i;
  logic                     arst_n_i;
  logic                     hold;
  logic                     heavy_bp;
  io_msg_pkg::lce_id_t      lce_id_i;
  io_msg_pkg::did_t         did_i;
  axil_pkg::axil_addr_t     awaddr_i;
  axil_pkg::axil_addr_t     araddr_i;
  axil_pkg::axil_addr_t     io_cmd_addr_o;
  axil_pkg::axil_data_t     wdata_i;
  axil_pkg::axil_data_t     rdata_o;
  axil_pkg::axil_data_t     io_cmd_data_o;
  axil_pkg::axil_data_t     io_resp_data_i;
  axil_pkg::axil_strb_t     wstrb_i;
  axil_pkg::axil_resp_t     bresp_o;
  axil_pkg::axil_resp_t     rresp_o;
  logic                     awvalid_i;
  logic                     awready_o;
  logic                     wvalid_i;
  logic                     wready_o;
  logic                     bvalid_o;
  logic                     bready_i;
  logic                     arvalid_i;
  logic                     arready_o;
  logic                     rvalid_o;
  logic                     rready_i;
  logic                     io_cmd_v_o;
  logic                     io_cmd_credit_i;
  logic                     io_resp_v_i;
  logic                     io_resp_credit_o;
  io_msg_pkg::io_msg_type_e io_cmd_type_o;
  io_msg_pkg::io_msg_type_e io_resp_type_i;
  io_msg_pkg::io_msg_size_e io_cmd_size_o;
  io_msg_pkg::lce_id_t      io_cmd_lce_id_o;
  io_msg_pkg::did_t         io_cmd_did_o;

  logic [31:0] shadow [8];
  logic [31:0] exp_wr_addr [$];
  logic [31:0] exp_wr_data [$];
  logic [3:0]  exp_wr_strb [$];
  logic [31:0] exp_rd_addr [$];
  logic [31:0] exp_rd_data [$];
  int          errors;
  int          wr_sent;
  int          rd_sent;
  int          wr_done;
  int          rd_done;
  int          cmd_outstanding;
  int          resp_credit_owed;

  axil_io_client #(.CMD_CREDITS_P(2)) u_axil_io_client (.*);

  tb_io_target_model u_target
  (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .hold_i           (hold),
    .io_cmd_v_i       (io_cmd_v_o),
    .io_cmd_type_i    (io_cmd_type_o),
    .io_cmd_size_i    (io_cmd_size_o),
    .io_cmd_addr_i    (io_cmd_addr_o),
    .io_cmd_data_i    (io_cmd_data_o),
    .io_cmd_credit_o  (io_cmd_credit_i),
    .io_resp_v_o      (io_resp_v_i),
    .io_resp_type_o   (io_resp_type_i),
    .io_resp_data_o   (io_resp_data_i),
    .io_resp_credit_i (io_resp_credit_o)
  );

  task automatic flag_mismatch(input string msg);
    errors++;
    $display("MISMATCH at %0t ns: %s", $time, msg);
  endtask

  function automatic io_msg_pkg::io_msg_size_e size_for_strb(input logic [3:0] s);
    if (s == 4'h1)
      return io_msg_pkg::e_io_size_1;
    if (s == 4'h3)
      return io_msg_pkg::e_io_size_2;
    return io_msg_pkg::e_io_size_4;
  endfunction

  // Header check against the oldest transaction of the same direction
  task automatic check_command();
    logic [31:0] a;
    logic [31:0] d;
    logic [3:0]  s;
    assert (io_cmd_lce_id_o == lce_id_i && io_cmd_did_o == did_i)
      else flag_mismatch("lce id or domain id wrong");
    if (io_cmd_type_o == io_msg_pkg::e_io_uc_wr)
    begin
      a = exp_wr_addr.pop_front();
      d = exp_wr_data.pop_front();
      s = exp_wr_strb.pop_front();
      assert (io_cmd_addr_o == a && io_cmd_data_o == d)
        else flag_mismatch($sformatf("write cmd addr %h data %h", io_cmd_addr_o, io_cmd_data_o));
      assert (io_cmd_size_o == size_for_strb(s))
        else flag_mismatch($sformatf("write size %0d for strobe %h", io_cmd_size_o, s));
      case (s)
        4'h1: shadow[a[4:2]][7:0] = d[7:0];
        4'h3: shadow[a[4:2]][15:0] = d[15:0];
        default: shadow[a[4:2]] = d;
      endcase
    end
    else
    begin
      a = exp_rd_addr.pop_front();
      assert (io_cmd_type_o == io_msg_pkg::e_io_uc_rd && io_cmd_addr_o == a)
        else flag_mismatch($sformatf("read cmd addr %h type %0d", io_cmd_addr_o, io_cmd_type_o));
      assert (io_cmd_size_o == io_msg_pkg::e_io_size_4 && io_cmd_data_o == '0)
        else flag_mismatch("read cmd size or data wrong");
      exp_rd_data.push_back(shadow[a[4:2]]);
    end
  endtask

  always @(negedge clk_i)
  begin
    logic [31:0] exp_d;
    if (arst_n_i)
    begin
      if (io_cmd_v_o)
        check_command();
      cmd_outstanding += int'(io_cmd_v_o) - int'(io_cmd_credit_i);
      resp_credit_owed += int'((bvalid_o && bready_i) || (rvalid_o && rready_i))
                          - int'(io_resp_credit_o);
      if (rvalid_o && rready_i)
      begin
        exp_d = exp_rd_data.pop_front();
        assert (rdata_o == exp_d)
          else flag_mismatch($sformatf("read data %h expected %h", rdata_o, exp_d));
        rd_done++;
      end
      if (bvalid_o && bready_i)
        wr_done++;
    end
  end

  // Protocol properties
  assert property (@(posedge clk_i) (!arst_n_i || $past(!arst_n_i)) |->
    !(bvalid_o || rvalid_o || io_cmd_v_o || io_resp_credit_o ||
      awready_o || wready_o || arready_o))
    else flag_mismatch("output active during or just after reset");
  assert property (@(posedge clk_i) cmd_outstanding <= 2)
    else flag_mismatch("more than 2 commands outstanding");
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (cmd_outstanding == 2 && !arready_o) |=> !arready_o)
    else flag_mismatch("read taken without a credit");
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (cmd_outstanding == 2 && !awready_o) |=> !awready_o)
    else flag_mismatch("write address taken without a credit");
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (cmd_outstanding == 2 && !wready_o) |=> !wready_o)
    else flag_mismatch("write data taken without a credit");
  assert property (@(posedge clk_i) resp_credit_owed >= 0)
    else flag_mismatch("response credit returned before its beat was accepted");
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (bvalid_o && !bready_i) |=> bvalid_o && $stable(bresp_o))
    else flag_mismatch("B beat dropped under back-pressure");
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (rvalid_o && !rready_i) |=> rvalid_o && $stable(rdata_o))
    else flag_mismatch("R beat changed under back-pressure");
  assert property (@(posedge clk_i) bvalid_o |-> bresp_o == axil_pkg::AXIL_RESP_OKAY)
    else flag_mismatch("B response code not OKAY");
  assert property (@(posedge clk_i) rvalid_o |-> rresp_o == axil_pkg::AXIL_RESP_OKAY)
    else flag_mismatch("R response code not OKAY");

  initial
  begin
    clk_i = 1'b0;
    forever
      #50 clk_i = ~clk_i;
  end

  initial
  begin
    #(N_TXN * 40 * 100);
    $display("Run hung: not all transactions completed before the watchdog expired");
    $display("Simulation FAILED");
    $finish;
  end

  // Random B and R back-pressure, much stronger while heavy_bp is set
  initial
  begin
    forever
    begin
      @(posedge clk_i);
      bready_i <= heavy_bp ? ($urandom_range(3) == 0) : ($urandom_range(3) != 0);
      rready_i <= heavy_bp ? ($urandom_range(3) == 0) : ($urandom_range(3) != 0);
    end
  end

  task automatic write_traffic(input int n);
    logic [31:0] a;
    logic [31:0] d;
    logic [3:0]  s;
    repeat (n)
    begin
      a = 32'h4000_0000 + 4 * $urandom_range(7);
      d = $urandom;
      s = ($urandom_range(2) == 0) ? 4'h1 : (($urandom_range(1) == 0) ? 4'h3 : 4'hf);
      exp_wr_addr.push_back(a);
      exp_wr_data.push_back(d);
      exp_wr_strb.push_back(s);
      wr_sent++;
      @(posedge clk_i);
      awaddr_i  <= a;
      awvalid_i <= 1'b1;
      wdata_i   <= d;
      wstrb_i   <= s;
      wvalid_i  <= 1'b1;
      fork
        begin
          do @(negedge clk_i); while (!awready_o);
          @(posedge clk_i);
          awvalid_i <= 1'b0;
        end
        begin
          do @(negedge clk_i); while (!wready_o);
          @(posedge clk_i);
          wvalid_i <= 1'b0;
        end
      join
    end
  endtask

  task automatic read_traffic(input int n);
    logic [31:0] a;
    repeat (n)
    begin
      a = 32'h4000_0000 + 4 * $urandom_range(7);
      exp_rd_addr.push_back(a);
      rd_sent++;
      @(posedge clk_i);
      araddr_i  <= a;
      arvalid_i <= 1'b1;
      do @(negedge clk_i); while (!arready_o);
      @(posedge clk_i);
      arvalid_i <= 1'b0;
    end
  endtask

  task automatic drain(input string name);
    while (wr_done != wr_sent || rd_done != rd_sent)
      @(posedge clk_i);
    $display("Test %s finished, errors so far %0d", name, errors);
  endtask

  initial
  begin
    void'($urandom(32'hd8450951));
    for (int i = 0; i < 8; i++)
      shadow[i] = (32'h4000_0000 + i * 4) * 32'h9e37_79b9;
    arst_n_i = 1'b0;
    hold = 1'b0;
    heavy_bp = 1'b0;
    lce_id_i = 4'h9;
    did_i = 3'h5;
    awaddr_i = '0;
    awvalid_i = 1'b0;
    wdata_i = '0;
    wstrb_i = '0;
    wvalid_i = 1'b0;
    araddr_i = '0;
    arvalid_i = 1'b0;
    bready_i = 1'b0;
    rready_i = 1'b0;
    repeat (8) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(posedge clk_i);
    @(posedge clk_i);
    $display("Test reset finished, errors so far %0d", errors);
    fork
      write_traffic(20);
      read_traffic(20);
    join
    drain("random traffic");
    // Target withholds credits so the holding registers fill
    hold <= 1'b1;
    fork
      write_traffic(4);
      read_traffic(4);
    join_none
    repeat (30) @(posedge clk_i);
    hold <= 1'b0;
    wait fork;
    drain("credit withholding");
    heavy_bp <= 1'b1;
    fork
      write_traffic(10);
      read_traffic(10);
    join
    drain("response back-pressure");
    $display("Done: %0d writes, %0d reads, %0d errors", wr_done, rd_done, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: tb_io_target_model.sv
module tb_io_target_model
(
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     hold_i,
  input  logic                     io_cmd_v_i,
  input  io_msg_pkg::io_msg_type_e io_cmd_type_i,
  input  io_msg_pkg::io_msg_size_e io_cmd_size_i,
  input  axil_pkg::axil_addr_t     io_cmd_addr_i,
  input  axil_pkg::axil_data_t     io_cmd_data_i,
  output logic                     io_cmd_credit_o,
  output logic                     io_resp_v_o,
  output io_msg_pkg::io_msg_type_e io_resp_type_o,
  output axil_pkg::axil_data_t     io_resp_data_o,
  input  logic                     io_resp_credit_i
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0]              mem [8];
  io_msg_pkg::io_msg_type_e pend_type [$];
  logic [31:0]              pend_data [$];
  int                       owed_credits;
  int                       resp_credits;

  initial
  begin
    for (int i = 0; i < 8; i++)
      mem[i] = (32'h4000_0000 + i * 4) * 32'h9e37_79b9;
    owed_credits    = 0;
    resp_credits    = io_msg_pkg::RESP_CREDITS;
    io_cmd_credit_o = 1'b0;
    io_resp_v_o     = 1'b0;
    io_resp_type_o  = io_msg_pkg::e_io_uc_rd;
    io_resp_data_o  = '0;
  end

  // Commands and returned credits are taken in mid-cycle
  always @(negedge clk_i)
  begin
    if (arst_n_i)
    begin
      if (io_resp_credit_i)
        resp_credits++;
      if (io_cmd_v_i)
      begin
        owed_credits++;
        pend_type.push_back(io_cmd_type_i);
        if (io_cmd_type_i == io_msg_pkg::e_io_uc_wr)
        begin
          case (io_cmd_size_i)
            io_msg_pkg::e_io_size_1: mem[io_cmd_addr_i[4:2]][7:0] = io_cmd_data_i[7:0];
            io_msg_pkg::e_io_size_2: mem[io_cmd_addr_i[4:2]][15:0] = io_cmd_data_i[15:0];
            default: mem[io_cmd_addr_i[4:2]] = io_cmd_data_i;
          endcase
          pend_data.push_back('0);
        end
        else
          pend_data.push_back(mem[io_cmd_addr_i[4:2]]);
      end
    end
  end

  // Credit returns and in-order responses after random delays
  always @(posedge clk_i)
  begin
    io_cmd_credit_o <= 1'b0;
    io_resp_v_o     <= 1'b0;
    if (arst_n_i)
    begin
      if (owed_credits > 0 && !hold_i && $urandom_range(2) == 0)
      begin
        io_cmd_credit_o <= 1'b1;
        owed_credits--;
      end
      if (pend_type.size() > 0 && resp_credits > 0 && $urandom_range(3) == 0)
      begin
        io_resp_v_o    <= 1'b1;
        io_resp_type_o <= pend_type.pop_front();
        io_resp_data_o <= pend_data.pop_front();
        resp_credits--;
      end
    end
  end

endmodule
